/* hdl/lcd_pkg.sv */
package lcd_pkg;

	typedef logic [9:0] lcd_word_t;     // {rs, rw, data[7:0]}
	typedef logic [6:0] lcd_cfg_t;      // N F D C B I/D S
	typedef logic [3:0] axil_addr_t;    // byte offset inside the block
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0] axil_resp_t;
	typedef logic [7:0] wait_us_t;      // strobe length in us
	typedef logic [2:0] fifo_count_t;   // occupancy, fits status bits 4:2

	localparam axil_addr_t ADDR_CONFIG = 4'h0;
	localparam axil_addr_t ADDR_CMD = 4'h4;
	localparam axil_addr_t ADDR_STATUS = 4'h8;
	localparam axil_addr_t ADDR_CTRL = 4'hC;

	localparam axil_resp_t RESP_OKAY = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	localparam lcd_cfg_t CFG_RESET = 7'h3C;

	typedef enum logic [2:0] {
		POWER_UP,
		INIT_ISSUE,
		INIT_WAIT,
		READY,
		CMD_WAIT
	} seq_state_t;

	typedef enum logic [1:0] {IDLE, SETUP, E_HIGH, HOLD} strobe_state_t;

endpackage

/* hdl/lcd_axil_regs.sv */
`timescale 1ns/1ps

module lcd_axil_regs
	import lcd_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  axil_addr_t  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  axil_data_t  wdata,
	input  logic        wvalid,
	output logic        wready,
	output axil_resp_t  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  axil_addr_t  araddr,
	input  logic        arvalid,
	output logic        arready,
	output axil_data_t  rdata,
	output axil_resp_t  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic        fifo_full,
	input  fifo_count_t fifo_count,
	input  logic        busy,
	input  logic        init_done,
	output lcd_cfg_t    cfg,
	output logic        push,
	output lcd_word_t   push_word,
	output logic        reinit
);

	logic aw_held;       // write address captured
	logic w_held;        // write data captured
	axil_addr_t aw_addr_q;
	axil_data_t w_data_q;
	logic wr_go;
	axil_data_t status_word;

	// no new write is taken while a response is pending
	assign awready = ~aw_held & ~bvalid;
	assign wready = ~w_held & ~bvalid;
	assign arready = ~rvalid;
	assign wr_go = aw_held & w_held;
	assign push_word = w_data_q[9:0];   // still stable in the push cycle
	assign status_word = {26'd0, fifo_full, fifo_count, init_done, busy};

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
		end else begin
			if (awvalid && awready)
				aw_held <= 1'b1;
			else if (wr_go)
				aw_held <= 1'b0;
			if (wvalid && wready)
				w_held <= 1'b1;
			else if (wr_go)
				w_held <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (awvalid && awready)
			aw_addr_q <= awaddr;
		if (wvalid && wready)
			w_data_q <= wdata;
	end

	// write decode, push and reinit are single-cycle pulses
	always_ff @(posedge clk) begin
		push <= 1'b0;
		reinit <= 1'b0;
		if (rst) begin
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			cfg <= CFG_RESET;
		end else begin
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_go) begin
				bvalid <= 1'b1;
				bresp <= RESP_OKAY;
				case (aw_addr_q)
					ADDR_CONFIG: cfg <= w_data_q[6:0];
					ADDR_CMD: begin
						if (fifo_full)
							bresp <= RESP_SLVERR;   // queue full, word dropped
						else
							push <= 1'b1;
					end
					ADDR_STATUS: begin
						// status is read only, write ignored
					end
					ADDR_CTRL: reinit <= w_data_q[0];
					default: bresp <= RESP_SLVERR;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			rvalid <= 1'b0;
		else if (arvalid && arready)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// read data sampled on address accept
	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			rresp <= RESP_OKAY;
			case (araddr)
				ADDR_CONFIG: rdata <= {25'd0, cfg};
				ADDR_STATUS: rdata <= status_word;
				ADDR_CMD, ADDR_CTRL: rdata <= '0;
				default: begin
					rdata <= '0;
					rresp <= RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

/* hdl/lcd_cmd_fifo.sv */
`timescale 1ns/1ps

module lcd_cmd_fifo
	import lcd_pkg::*;
#(
	parameter int fifo_depth = 4
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        push,
	input  lcd_word_t   push_word,
	input  logic        pop,
	output lcd_word_t   head,
	output logic        empty,
	output logic        full,
	output fifo_count_t count
);

	localparam int PW = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam logic [PW-1:0] LAST = PW'(fifo_depth - 1);

	lcd_word_t mem [fifo_depth];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;

	assign head = mem[rd_ptr];   // show-ahead
	assign empty = (count == '0);
	assign full = (count == fifo_count_t'(fifo_depth));

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_word;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

endmodule

/* hdl/lcd_init_seq.sv */
`timescale 1ns/1ps

module lcd_init_seq
	import lcd_pkg::*;
#(
	parameter int clk_mhz = 35
) (
	input  logic      clk,
	input  logic      rst,
	input  lcd_cfg_t  cfg,
	input  logic      reinit,
	input  logic      empty,
	input  lcd_word_t head,
	input  logic      ready,
	input  logic      done,
	output logic      pop,
	output logic      start,
	output lcd_word_t word,
	output wait_us_t  wait_us,
	output logic      busy,
	output logic      init_done
);

	localparam int PU_CYCLES = 500 * clk_mhz;   // 500 us power-up wait
	localparam int PW = $clog2(PU_CYCLES);
	localparam wait_us_t CMD_HOLD = 8'd50;

	seq_state_t state;
	logic [PW-1:0] pu_cnt;
	logic [1:0] step;        // init command index
	lcd_word_t init_word;
	wait_us_t init_hold;
	logic issue_init;
	logic issue_cmd;

	// init commands built from the live config
	always_comb begin
		case (step)
			2'd0: begin
				init_word = {2'b00, 4'b0011, cfg[6], cfg[5], 2'b00};   // function set
				init_hold = 8'd50;
			end
			2'd1: begin
				init_word = {2'b00, 5'b00001, cfg[4:2]};   // display on/off
				init_hold = 8'd50;
			end
			2'd2: begin
				init_word = 10'h001;   // clear
				init_hold = 8'd200;
			end
			default: begin
				init_word = {2'b00, 6'b000001, cfg[1:0]};   // entry mode
				init_hold = 8'd100;
			end
		endcase
	end

	// start goes out in the cycle the strobe is free
	assign issue_init = (state == INIT_ISSUE) && ready && !reinit;
	assign issue_cmd = (state == READY) && !empty && ready && !reinit;
	assign start = issue_init | issue_cmd;
	assign pop = issue_cmd;
	assign word = issue_cmd ? head : init_word;
	assign wait_us = issue_cmd ? CMD_HOLD : init_hold;
	assign busy = !((state == READY) && empty);

	always_ff @(posedge clk) begin
		if (rst || reinit) begin
			state <= POWER_UP;
			pu_cnt <= '0;
			step <= 2'd0;
			init_done <= 1'b0;
		end else begin
			case (state)
				POWER_UP: begin
					if (pu_cnt == PW'(PU_CYCLES - 1)) begin
						pu_cnt <= '0;
						state <= INIT_ISSUE;
					end else begin
						pu_cnt <= pu_cnt + 1'b1;
					end
				end
				INIT_ISSUE: begin
					if (issue_init)
						state <= INIT_WAIT;
				end
				INIT_WAIT: begin
					if (done) begin
						if (step == 2'd3) begin   // entry mode was last
							init_done <= 1'b1;
							state <= READY;
						end else begin
							step <= step + 1'b1;
							state <= INIT_ISSUE;
						end
					end
				end
				READY: begin
					if (issue_cmd)
						state <= CMD_WAIT;
				end
				CMD_WAIT: begin
					if (done)
						state <= READY;
				end
				default: state <= POWER_UP;
			endcase
		end
	end

endmodule

/* hdl/lcd_strobe.sv */
`timescale 1ns/1ps

module lcd_strobe
	import lcd_pkg::*;
#(
	parameter int clk_mhz = 35
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  lcd_word_t  word,
	input  wait_us_t   wait_us,
	input  logic       abort,
	output logic       ready,
	output logic       done,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);

	localparam int CW = $clog2(256 * clk_mhz);
	localparam logic [CW-1:0] SETUP_END = CW'(clk_mhz);      // 1 us setup
	localparam logic [CW-1:0] E_END = CW'(14 * clk_mhz);     // plus 13 us enable

	strobe_state_t state;
	logic [CW-1:0] cnt;     // cycles since start
	logic [CW-1:0] limit;   // total strobe length

	assign ready = (state == IDLE);

	always_ff @(posedge clk) begin
		done <= 1'b0;
		if (rst || abort) begin
			state <= IDLE;
			cnt <= '0;
			limit <= '0;
			e <= 1'b0;
			rs <= 1'b0;
			rw <= 1'b0;
			lcd_data <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= SETUP;
						cnt <= CW'(1);
						limit <= CW'(wait_us * clk_mhz);
						rs <= word[9];
						rw <= word[8];
						lcd_data <= word[7:0];
					end
				end
				SETUP: begin
					cnt <= cnt + 1'b1;
					if (cnt == SETUP_END) begin
						e <= 1'b1;
						state <= E_HIGH;
					end
				end
				E_HIGH: begin
					cnt <= cnt + 1'b1;
					if (cnt == E_END) begin
						e <= 1'b0;   // LCD latches on this edge
						state <= HOLD;
					end
				end
				HOLD: begin
					cnt <= cnt + 1'b1;
					if (cnt == limit) begin
						done <= 1'b1;
						rs <= 1'b0;
						rw <= 1'b0;
						lcd_data <= '0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* hdl/lcd_top.sv */
`timescale 1ns/1ps

module lcd_top
	import lcd_pkg::*;
#(
	parameter int clk_mhz = 35,
	parameter int fifo_depth = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  axil_addr_t awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  axil_data_t wdata,
	input  logic       wvalid,
	output logic       wready,
	output axil_resp_t bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axil_addr_t araddr,
	input  logic       arvalid,
	output logic       arready,
	output axil_data_t rdata,
	output axil_resp_t rresp,
	output logic       rvalid,
	input  logic       rready,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);

	lcd_cfg_t cfg;
	logic push;
	lcd_word_t push_word;
	logic reinit;
	logic pop;
	lcd_word_t head;
	logic empty;
	logic full;
	fifo_count_t count;
	logic busy;
	logic init_done;
	logic start;
	lcd_word_t word;
	wait_us_t wait_us;
	logic ready;
	logic done;

	lcd_axil_regs regs_i (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.fifo_full(full), .fifo_count(count), .busy(busy), .init_done(init_done),
		.cfg(cfg), .push(push), .push_word(push_word), .reinit(reinit)
	);

	lcd_cmd_fifo #(.fifo_depth(fifo_depth)) fifo_i (
		.clk(clk), .rst(rst), .push(push), .push_word(push_word), .pop(pop),
		.head(head), .empty(empty), .full(full), .count(count)
	);

	lcd_init_seq #(.clk_mhz(clk_mhz)) seq_i (
		.clk(clk), .rst(rst), .cfg(cfg), .reinit(reinit),
		.empty(empty), .head(head), .ready(ready), .done(done),
		.pop(pop), .start(start), .word(word), .wait_us(wait_us),
		.busy(busy), .init_done(init_done)
	);

	lcd_strobe #(.clk_mhz(clk_mhz)) strobe_i (
		.clk(clk), .rst(rst), .start(start), .word(word), .wait_us(wait_us),
		.abort(reinit), .ready(ready), .done(done),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data)
	);

endmodule

/* verification/lcd_chk.sv */
`timescale 1ns/1ps

module lcd_chk #(
	parameter int clk_mhz = 35
) (
	input logic       clk,
	input logic       rst,
	input logic       e,
	input logic       rs,
	input logic       rw,
	input logic [7:0] lcd_data,
	input logic       bvalid,
	input logic       bready,
	input logic       rvalid,
	input logic       rready
);

	localparam int E_MAX = 13 * clk_mhz;   // enable pulse length in cycles

	int e_run;   // cycles e has been high so far

	always_ff @(posedge clk) begin
		if (rst || !e)
			e_run <= 0;
		else
			e_run <= e_run + 1;
	end

	pins_stable: assert property (@(posedge clk) disable iff (rst)
		e && $past(e) |-> $stable({rs, rw, lcd_data}))
		else $error("lcd pins changed while e was high");

	e_width: assert property (@(posedge clk) disable iff (rst)
		e |-> e_run < E_MAX)
		else $error("e stayed high longer than the enable time");

	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

endmodule

bind lcd_top lcd_chk #(.clk_mhz(clk_mhz)) chk_i (
	.clk(clk), .rst(rst),
	.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data),
	.bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready)
);

/* verification/lcd_tb.sv */
`timescale 1ns/1ps

module lcd_tb
	import lcd_pkg::*;
();

	localparam int clk_mhz = 1;   // 1 cycle per us keeps delays short
	localparam string tests_path = "verification/lcd_tests.txt";

	logic clk;
	logic rst;
	axil_addr_t awaddr;
	logic awvalid;
	logic awready;
	axil_data_t wdata;
	logic wvalid;
	logic wready;
	axil_resp_t bresp;
	logic bvalid;
	logic bready;
	axil_addr_t araddr;
	logic arvalid;
	logic arready;
	axil_data_t rdata;
	axil_resp_t rresp;
	logic rvalid;
	logic rready;
	logic e;
	logic rs;
	logic rw;
	logic [7:0] lcd_data;

	lcd_word_t captured [$];   // words latched by the LCD in order
	logic e_q = 1'b0;
	int cycles = 0;
	int cycle_limit = 0;

	lcd_top #(.clk_mhz(clk_mhz), .fifo_depth(4)) dut_i (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data)
	);

	always #4 clk = ~clk;

	// falling edge of e is where the LCD takes the word
	always @(posedge clk) begin
		e_q <= e;
		if (e_q && !e)
			captured.push_back({rs, rw, lcd_data});
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: run passed the limit of %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$fatal(1, "simulation did not finish in time");
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s expected 0x%0h got 0x%0h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic bad_line(input string op);
		$display("unreadable line in %s starting with %s", tests_path, op);
		$display("TEST FAIL");
		$fatal(1, "bad test file");
	endtask

	task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
			output axil_resp_t resp);
		logic aw_done;
		logic w_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		bready <= 1'b0;
		while (!(aw_done && w_done)) begin
			@(posedge clk);
			if (awvalid && awready) begin
				aw_done = 1'b1;
				awvalid <= 1'b0;
			end
			if (wvalid && wready) begin
				w_done = 1'b1;
				wvalid <= 1'b0;
			end
		end
		@(posedge clk);
		while (!bvalid)
			@(posedge clk);
		repeat (2) @(posedge clk);   // slave has to hold bvalid meanwhile
		bready <= 1'b1;
		@(posedge clk);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axi_read(input axil_addr_t addr, output axil_data_t data,
			output axil_resp_t resp);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b0;
		@(posedge clk);
		while (!arready)
			@(posedge clk);
		arvalid <= 1'b0;
		@(posedge clk);
		while (!rvalid)
			@(posedge clk);
		repeat (2) @(posedge clk);   // slave has to hold rvalid meanwhile
		rready <= 1'b1;
		@(posedge clk);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	task automatic next_pin_word(output lcd_word_t word);
		while (captured.size() == 0)
			@(posedge clk);
		word = captured.pop_front();
	endtask

	// budget is the idle cycles plus a margin per operation
	task automatic compute_limit(output int limit);
		int fd;
		int n;
		int t;
		int total;
		string op;
		string rest;
		total = 0;
		fd = $fopen(tests_path, "r");
		if (fd == 0) begin
			$display("cannot open %s", tests_path);
			$display("TEST FAIL");
			$fatal(1, "missing test file");
		end else begin
			while ($fscanf(fd, "%s", op) == 1) begin
				if (op == "T") begin
					n = $fscanf(fd, "%d", t);
					total += t;
				end else begin
					if (op == "E")
						total += 1000;
					else if (op == "W" || op == "R")
						total += 50;
					n = $fgets(rest, fd);
				end
			end
			$fclose(fd);
			limit = 2 * total;
		end
	endtask

	task automatic run_tests();
		int fd;
		int n;
		int t;
		string op;
		string rest;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] resp;
		axil_data_t got_data;
		axil_resp_t got_resp;
		lcd_word_t got_word;
		fd = $fopen(tests_path, "r");
		while ($fscanf(fd, "%s", op) == 1) begin
			if (op.substr(0, 0) == "#") begin
				n = $fgets(rest, fd);
			end else if (op == "W") begin
				n = $fscanf(fd, "%h %h %h", addr, data, resp);
				if (n != 3)
					bad_line(op);
				axi_write(addr[3:0], data, got_resp);
				check("bresp", resp, 32'(got_resp));
			end else if (op == "R") begin
				n = $fscanf(fd, "%h %h %h", addr, data, resp);
				if (n != 3)
					bad_line(op);
				axi_read(addr[3:0], got_data, got_resp);
				check("rdata", data, got_data);
				check("rresp", resp, 32'(got_resp));
			end else if (op == "E") begin
				n = $fscanf(fd, "%h", data);
				if (n != 1)
					bad_line(op);
				next_pin_word(got_word);
				check("lcd word", data, 32'(got_word));
			end else if (op == "T") begin
				n = $fscanf(fd, "%d", t);
				if (n != 1)
					bad_line(op);
				repeat (t) @(posedge clk);
			end else begin
				bad_line(op);
			end
		end
		$fclose(fd);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		compute_limit(cycle_limit);
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check("lcd pins", 32'd0, 32'({e, rs, rw, lcd_data}));
		check("ready signals", 32'h7, 32'({awready, wready, arready}));
		check("valid signals", 32'h0, 32'({bvalid, rvalid}));
		run_tests();
		$display("TEST PASS");
		$finish;
	end

endmodule

/* vlog.f */
hdl/lcd_pkg.sv
hdl/lcd_axil_regs.sv
hdl/lcd_cmd_fifo.sv
hdl/lcd_init_seq.sv
hdl/lcd_strobe.sv
hdl/lcd_top.sv
verification/lcd_chk.sv
verification/lcd_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = lcd_tb
FILELIST = vlog.f
OBJ_DIR = obj_dir

.PHONY: sim clean

# the simulator exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verification/lcd_tests.txt */
# W/R addr data resp, all hex; E word expects the next strobe {rs,rw,data} in hex
# T n waits n cycles, decimal
R 0 3c 0
R 8 1 0
W 0 52 0
W 4 241 0
W 4 242 0
W 4 143 0
W 4 044 0
W 4 255 2
R 8 31 0
W 2 12 2
R 6 0 2
R 4 0 0
R c 0 0
E 038
E 00c
E 001
E 006
E 241
E 242
E 143
E 044
T 60
R 8 2 0
W 0 27 0
W c 1 0
R 8 1 0
R 0 27 0
E 034
E 009
E 001
E 007
T 120
R 8 2 0
